//--- Makefile
TOOL     = verilator
TOP      = petConsoleTb
FILELIST = list.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS     = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, then check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- list.f
+incdir+logic
logic/petConsolePkg.sv
logic/serialDecoder.sv
logic/reportComposer.sv
logic/serialReporter.sv
logic/petConsole.sv
verification/clockGen.sv
verification/petConsoleTb.sv

//--- logic/petConsole.sv
`timescale 1ns/1ps
`default_nettype none

`include "petConsole_macros.svh"

module petConsole #(
    parameter int bitPeriod = `BIT_PERIOD_DEFAULT,
    parameter int holdCycles = `HOLD_CYCLES_DEFAULT
) (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    rxLine,
    input  wire logic                    btnN,
    input  wire petConsolePkg::stat_t    hunger,
    input  wire petConsolePkg::stat_t    happiness,
    input  wire petConsolePkg::stat_t    health,
    input  wire petConsolePkg::stat_t    hygiene,
    input  wire petConsolePkg::stat_t    energy,
    input  wire petConsolePkg::stat_t    social,
    output wire logic                    txLine,
    output petConsolePkg::byte_t         rxData
);

    wire logic reportStart;
    petConsolePkg::charIndex_t charIndex;
    petConsolePkg::byte_t reportChar;

    serialDecoder #(
        .bitPeriod(bitPeriod)
    ) i_serialDecoder (
        .clk(clk),
        .rstN(rstN),
        .rxLine(rxLine),
        .rxData(rxData)
    );

    reportComposer i_reportComposer (
        .clk(clk),
        .rstN(rstN),
        .reportStart(reportStart),
        .hunger(hunger),
        .happiness(happiness),
        .health(health),
        .hygiene(hygiene),
        .energy(energy),
        .social(social),
        .charIndex(charIndex),
        .reportChar(reportChar)
    );

    serialReporter #(
        .bitPeriod(bitPeriod),
        .holdCycles(holdCycles)
    ) i_serialReporter (
        .clk(clk),
        .rstN(rstN),
        .btnN(btnN),
        .reportChar(reportChar),
        .reportStart(reportStart),
        .charIndex(charIndex),
        .txLine(txLine)
    );

endmodule

`default_nettype wire

//--- logic/petConsolePkg.sv
`default_nettype none

`include "petConsole_macros.svh"

package petConsolePkg;

    typedef logic [`BYTE_WIDTH-1:0] byte_t;
    typedef logic [`STAT_WIDTH-1:0] stat_t;
    typedef logic [`INDEX_WIDTH-1:0] charIndex_t;

    typedef enum logic [2:0] {
        rxIdle,
        rxStart,
        rxWait,
        rxSample,
        rxStop
    } rxState_e;

    typedef enum logic [2:0] {
        txIdle,
        txStart,
        txData,
        txStop,
        txHold
    } txState_e;

    // stat lines in screen order
    typedef enum logic [2:0] {
        hunger,
        happiness,
        health,
        hygiene,
        energy,
        social
    } statId_e;

endpackage

`default_nettype wire

//--- logic/petConsole_macros.svh
`ifndef PETCONSOLE_MACROS_SVH
`define PETCONSOLE_MACROS_SVH

// serial character size
`define BYTE_WIDTH 8

// stat range
`define STAT_WIDTH 4
// also the base for the inverted display lines
`define STAT_MAX 15

// status screen size
`define REPORT_LENGTH 80
`define INDEX_WIDTH 7

// 27 MHz clock at 115200 baud
`define BIT_PERIOD_DEFAULT 234

// wait after a report before the button is looked at again
`define HOLD_CYCLES_DEFAULT 262143

// wide enough for the hold wait
`define COUNT_WIDTH 18

`endif

//--- logic/reportComposer.sv
`timescale 1ns/1ps
`default_nettype none

`include "petConsole_macros.svh"

module reportComposer (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        reportStart,
    input  wire petConsolePkg::stat_t        hunger,
    input  wire petConsolePkg::stat_t        happiness,
    input  wire petConsolePkg::stat_t        health,
    input  wire petConsolePkg::stat_t        hygiene,
    input  wire petConsolePkg::stat_t        energy,
    input  wire petConsolePkg::stat_t        social,
    input  wire petConsolePkg::charIndex_t   charIndex,
    output petConsolePkg::byte_t             reportChar
);

    localparam int statCount = petConsolePkg::social + 1;
    localparam int leftEye = 10;
    localparam int rightEye = 12;

    // digit fields hold "00" and are filled in below
    localparam logic [`REPORT_LENGTH*`BYTE_WIDTH-1:0] screenTemplate = {
        "(\\__/)\r\n",
        "(>'.'<)\r\n",
        "(\")_(\")\r\n",
        "STATS\r\n",
        "HU: 00\r\n",
        "HA: 00\r\n",
        "HE: 00\r\n",
        "HY: 00\r\n",
        "E: 00\r\n",
        "SO: 00\r\n"
    };

    // tens digit position of each stat line
    localparam int tensPos [statCount] = '{37, 45, 53, 61, 68, 76};

    petConsolePkg::stat_t snapshot [statCount];
    petConsolePkg::statId_e line;
    petConsolePkg::stat_t shown;
    petConsolePkg::stat_t unitsValue;
    logic isDigit;
    logic anyMax;

    // one set of values per report
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < statCount; i++) begin
                snapshot[i] <= '0;
            end
        end else if (reportStart) begin
            snapshot[petConsolePkg::hunger] <= hunger;
            snapshot[petConsolePkg::happiness] <= happiness;
            snapshot[petConsolePkg::health] <= health;
            snapshot[petConsolePkg::hygiene] <= hygiene;
            snapshot[petConsolePkg::energy] <= energy;
            snapshot[petConsolePkg::social] <= social;
        end
    end

    always_comb begin
        anyMax = 1'b0;
        for (int i = 0; i < statCount; i++) begin
            if (snapshot[i] == `STAT_WIDTH'(`STAT_MAX)) begin
                anyMax = 1'b1;
            end
        end
    end

    // which stat line, if any, the index falls on
    always_comb begin
        line = petConsolePkg::hunger;
        isDigit = 1'b0;
        for (int i = 0; i < statCount; i++) begin
            if (charIndex == tensPos[i] || charIndex == tensPos[i] + 1) begin
                line = petConsolePkg::statId_e'(i);
                isDigit = 1'b1;
            end
        end
    end

    // hunger raw, the rest counted down from the max
    assign shown = (line == petConsolePkg::hunger) ? snapshot[line]
                                                   : `STAT_WIDTH'(`STAT_MAX) - snapshot[line];
    assign unitsValue = (shown >= 4'd10) ? shown - 4'd10 : shown;

    always_comb begin
        reportChar = screenTemplate[(`REPORT_LENGTH - 1 - charIndex) * `BYTE_WIDTH +: `BYTE_WIDTH];
        if ((charIndex == leftEye || charIndex == rightEye) && anyMax) begin
            reportChar = "X";
        end
        if (isDigit) begin
            if (charIndex == tensPos[line]) begin
                reportChar = (shown >= 4'd10) ? "1" : "0";
            end else begin
                reportChar = "0" + {4'h0, unitsValue};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/serialDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "petConsole_macros.svh"

module serialDecoder #(
    parameter int bitPeriod = `BIT_PERIOD_DEFAULT
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 rxLine,
    output petConsolePkg::byte_t      rxData
);

    localparam logic [`COUNT_WIDTH-1:0] lastTick = `COUNT_WIDTH'(bitPeriod - 1);
    localparam logic [`COUNT_WIDTH-1:0] halfTick = `COUNT_WIDTH'(bitPeriod / 2);
    localparam logic [2:0] lastBit = 3'(`BYTE_WIDTH - 1);

    petConsolePkg::rxState_e rxState;
    logic [`COUNT_WIDTH-1:0] tickCount;
    logic [2:0] bitCount;
    logic frameDone;
    petConsolePkg::byte_t shiftReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxState <= petConsolePkg::rxIdle;
            tickCount <= '0;
            bitCount <= '0;
            frameDone <= 1'b0;
        end else begin
            case (rxState)
                petConsolePkg::rxIdle: begin
                    // falling edge of the start bit
                    if (!rxLine) begin
                        rxState <= petConsolePkg::rxStart;
                        tickCount <= `COUNT_WIDTH'(1);
                        bitCount <= '0;
                        frameDone <= 1'b0;
                    end
                end
                petConsolePkg::rxStart: begin
                    // move to the middle of the start bit
                    if (tickCount == halfTick) begin
                        rxState <= petConsolePkg::rxWait;
                        tickCount <= `COUNT_WIDTH'(1);
                    end else begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                petConsolePkg::rxWait: begin
                    tickCount <= tickCount + 1'b1;
                    if (tickCount == lastTick) begin
                        rxState <= petConsolePkg::rxSample;
                    end
                end
                petConsolePkg::rxSample: begin
                    tickCount <= `COUNT_WIDTH'(1);
                    bitCount <= bitCount + 1'b1;
                    if (bitCount == lastBit) begin
                        rxState <= petConsolePkg::rxStop;
                    end else begin
                        rxState <= petConsolePkg::rxWait;
                    end
                end
                petConsolePkg::rxStop: begin
                    // stop bit level is not checked
                    tickCount <= tickCount + 1'b1;
                    if (tickCount == lastTick) begin
                        rxState <= petConsolePkg::rxIdle;
                        tickCount <= '0;
                        frameDone <= 1'b1;
                    end
                end
                default: rxState <= petConsolePkg::rxIdle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (rxState == petConsolePkg::rxSample) begin
            shiftReg <= {rxLine, shiftReg[`BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxData <= '0;
        end else begin
            rxData <= frameDone ? shiftReg : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/serialReporter.sv
`timescale 1ns/1ps
`default_nettype none

`include "petConsole_macros.svh"

module serialReporter #(
    parameter int bitPeriod = `BIT_PERIOD_DEFAULT,
    parameter int holdCycles = `HOLD_CYCLES_DEFAULT
) (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        btnN,
    input  wire petConsolePkg::byte_t        reportChar,
    output logic                             reportStart,
    output petConsolePkg::charIndex_t        charIndex,
    output logic                             txLine
);

    localparam logic [`COUNT_WIDTH-1:0] lastTick = `COUNT_WIDTH'(bitPeriod - 1);
    localparam logic [`COUNT_WIDTH-1:0] lastHold = `COUNT_WIDTH'(holdCycles - 1);
    localparam logic [2:0] lastBit = 3'(`BYTE_WIDTH - 1);
    localparam petConsolePkg::charIndex_t lastChar = `INDEX_WIDTH'(`REPORT_LENGTH - 1);

    petConsolePkg::txState_e txState;
    logic [`COUNT_WIDTH-1:0] tickCount;
    logic [2:0] bitIndex;
    logic bitDone;
    petConsolePkg::byte_t dataOut;

    assign bitDone = (tickCount == lastTick);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            txState <= petConsolePkg::txIdle;
            tickCount <= '0;
            bitIndex <= '0;
            charIndex <= '0;
            reportStart <= 1'b0;
            txLine <= 1'b1;
        end else begin
            reportStart <= 1'b0;
            case (txState)
                petConsolePkg::txIdle: begin
                    txLine <= 1'b1;
                    tickCount <= '0;
                    if (!btnN) begin
                        txState <= petConsolePkg::txStart;
                        charIndex <= '0;
                        reportStart <= 1'b1;
                    end
                end
                petConsolePkg::txStart: begin
                    txLine <= 1'b0;
                    if (bitDone) begin
                        txState <= petConsolePkg::txData;
                        bitIndex <= '0;
                        tickCount <= '0;
                    end else begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                petConsolePkg::txData: begin
                    txLine <= dataOut[bitIndex];
                    if (bitDone) begin
                        tickCount <= '0;
                        if (bitIndex == lastBit) begin
                            txState <= petConsolePkg::txStop;
                        end else begin
                            bitIndex <= bitIndex + 1'b1;
                        end
                    end else begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                petConsolePkg::txStop: begin
                    txLine <= 1'b1;
                    if (bitDone) begin
                        tickCount <= '0;
                        if (charIndex == lastChar) begin
                            txState <= petConsolePkg::txHold;
                        end else begin
                            charIndex <= charIndex + 1'b1;
                            txState <= petConsolePkg::txStart;
                        end
                    end else begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                petConsolePkg::txHold: begin
                    // a held button gives just one report
                    txLine <= 1'b1;
                    if (tickCount == lastHold) begin
                        if (btnN) begin
                            txState <= petConsolePkg::txIdle;
                        end
                    end else begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                default: txState <= petConsolePkg::txIdle;
            endcase
        end
    end

    // character fetched at the end of its start bit
    always_ff @(posedge clk) begin
        if (txState == petConsolePkg::txStart && bitDone) begin
            dataOut <= reportChar;
        end
    end

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int periodNs = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- verification/petConsoleTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "petConsole_macros.svh"

module petConsoleTb;

    localparam int bitPeriod = 8;
    localparam int holdCycles = 16;
    localparam int statCount = 6;
    localparam int rxFrames = 8;
    localparam int frameCycles = 10 * bitPeriod;
    localparam int reportCycles = `REPORT_LENGTH * frameCycles;
    // five reports of about 6400 cycles, the receive frames with their gaps, and margin
    localparam int cycleLimit = 40000;

    wire logic clk;
    logic rstN;
    logic rxLine;
    logic btnN;
    wire logic txLine;
    petConsolePkg::byte_t rxData;
    petConsolePkg::stat_t statValue [statCount];
    petConsolePkg::stat_t pressStats [statCount];

    logic [31:0] lfsrState;
    int cycleCount;
    int valueErrors;
    int otherErrors;
    petConsolePkg::byte_t screenText [$];
    petConsolePkg::byte_t received [`REPORT_LENGTH];

    clockGen #(
        .periodNs(100)
    ) i_clockGen (
        .clk(clk)
    );

    petConsole #(
        .bitPeriod(bitPeriod),
        .holdCycles(holdCycles)
    ) i_petConsole (
        .clk(clk),
        .rstN(rstN),
        .rxLine(rxLine),
        .btnN(btnN),
        .hunger(statValue[0]),
        .happiness(statValue[1]),
        .health(statValue[2]),
        .hygiene(statValue[3]),
        .energy(statValue[4]),
        .social(statValue[5]),
        .txLine(txLine),
        .rxData(rxData)
    );

    // line idle and no byte held in reset
    resetIdle: assert property (@(negedge clk) !rstN |-> (txLine && rxData == '0))
        else begin
            otherErrors = otherErrors + 1;
            $display("txLine or rxData not idle during reset");
        end

    // taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomValue(int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    task automatic appendLine(string text);
        for (int i = 0; i < text.len(); i++) begin
            screenText.push_back(text[i]);
        end
        screenText.push_back(8'h0d);
        screenText.push_back(8'h0a);
    endtask

    task automatic buildScreen();
        appendLine("(\\__/)");
        appendLine("(>'.'<)");
        appendLine("(\")_(\")");
        appendLine("STATS");
        appendLine("HU: 00");
        appendLine("HA: 00");
        appendLine("HE: 00");
        appendLine("HY: 00");
        appendLine("E: 00");
        appendLine("SO: 00");
    endtask

    function automatic petConsolePkg::byte_t expectedChar(int idx);
        int line;
        int shown;
        logic anyMax;
        petConsolePkg::byte_t ch;
        ch = screenText[idx];
        anyMax = 1'b0;
        for (int s = 0; s < statCount; s++) begin
            if (pressStats[s] == `STAT_MAX) begin
                anyMax = 1'b1;
            end
        end
        if ((idx == 10 || idx == 12) && anyMax) begin
            ch = "X";
        end
        // stat line number from the colons before this position
        line = -1;
        for (int i = 0; i < idx; i++) begin
            if (screenText[i] == ":") begin
                line++;
            end
        end
        if (line >= 0) begin
            shown = (line == 0) ? pressStats[0] : `STAT_MAX - pressStats[line];
            if (screenText[idx - 2] == ":") begin
                ch = 8'(48 + shown / 10);
            end else if (idx >= 3 && screenText[idx - 3] == ":") begin
                ch = 8'(48 + shown % 10);
            end
        end
        return ch;
    endfunction

    task automatic checkValue(string testName, int expected, int actual);
        assert (expected == actual) else begin
            valueErrors = valueErrors + 1;
            $display("ERR %s: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    task automatic randomizeStats();
        for (int s = 0; s < statCount; s++) begin
            statValue[s] = petConsolePkg::stat_t'(randomValue(`STAT_WIDTH) % 15);
        end
    endtask

    task automatic sendByte(petConsolePkg::byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int b = 0; b < 10; b++) begin
            rxLine = frame[b];
            repeat (bitPeriod) @(negedge clk);
        end
    endtask

    task automatic receiveReport();
        for (int c = 0; c < `REPORT_LENGTH; c++) begin
            while (txLine !== 1'b0) begin
                @(negedge clk);
            end
            // middle of the start bit
            repeat (bitPeriod / 2 - 1) @(negedge clk);
            assert (txLine === 1'b0) else begin
                otherErrors = otherErrors + 1;
                $display("start bit of character %0d ended too early", c);
            end
            for (int b = 0; b < `BYTE_WIDTH; b++) begin
                repeat (bitPeriod) @(negedge clk);
                received[c][b] = txLine;
            end
            repeat (bitPeriod) @(negedge clk);
            assert (txLine === 1'b1) else begin
                otherErrors = otherErrors + 1;
                $display("stop bit of character %0d was low", c);
            end
        end
    endtask

    task automatic checkReport(string testName);
        for (int c = 0; c < `REPORT_LENGTH; c++) begin
            checkValue($sformatf("%s char %0d", testName, c), expectedChar(c), received[c]);
        end
    endtask

    task automatic runReport(string testName, bit changeMid);
        pressStats = statValue;
        btnN = 1'b0;
        fork
            receiveReport();
            begin
                repeat (2) @(negedge clk);
                btnN = 1'b1;
                if (changeMid) begin
                    repeat (reportCycles / 2) @(negedge clk);
                    randomizeStats();
                end
            end
        join
        checkReport(testName);
        // hold time runs out before the next press
        repeat (holdCycles + bitPeriod) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        petConsolePkg::byte_t value;
        int maxIndex;
        lfsrState = 32'hc5da_7c8a;
        cycleCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        rstN = 1'b0;
        rxLine = 1'b1;
        btnN = 1'b1;
        for (int s = 0; s < statCount; s++) begin
            statValue[s] = '0;
        end
        pressStats = statValue;
        buildScreen();
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("reset txLine", 1, txLine);
        checkValue("reset rxData", 0, rxData);

        for (int n = 0; n < rxFrames; n++) begin
            value = petConsolePkg::byte_t'(randomValue(`BYTE_WIDTH));
            fork
                sendByte(value);
                begin
                    repeat (3) @(negedge clk);
                    checkValue("rx clear", 0, rxData);
                end
            join
            checkValue("rx byte", value, rxData);
            repeat (frameCycles) @(negedge clk);
            checkValue("rx byte held", value, rxData);
        end

        randomizeStats();
        runReport("random stats", 1'b0);

        randomizeStats();
        maxIndex = int'(randomValue(3) % statCount);
        statValue[maxIndex] = petConsolePkg::stat_t'(`STAT_MAX);
        runReport("max stat", 1'b0);

        randomizeStats();
        runReport("mid change", 1'b1);

        // button held well past the report and the hold time
        randomizeStats();
        pressStats = statValue;
        btnN = 1'b0;
        receiveReport();
        checkReport("held button");
        for (int i = 0; i < holdCycles + 2 * frameCycles; i++) begin
            @(negedge clk);
            assert (txLine === 1'b1) else begin
                otherErrors = otherErrors + 1;
                $display("txLine left idle while the button was still held");
            end
        end
        btnN = 1'b1;
        repeat (4) @(negedge clk);
        randomizeStats();
        runReport("second press", 1'b0);

        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
